/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, then judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module trigger_serdes_tb \
	-f trigger_serdes.f -o trigger_serdes_sim > build.log 2>&1 \
	&& ./obj_dir/trigger_serdes_sim | tee sim.log \
	|| { cat build.log; echo "build or simulation returned an error" | tee -a sim.log; }
grep -q "Something failed" sim.log && exit 1
grep -q "Everything OK" sim.log || exit 1
exit 0

/* tb/trigger_serdes_tb.sv */
`timescale 1ns/1ps

module trigger_serdes_tb;
	import trigger_pkg::*;

	localparam int reset_cycles = 5;
	localparam int drive_delay = 2; // ns after the rising edge
	localparam int ready_clocks = 1 << ready_delay_bits;
	localparam int pair_spacing = 1 << (pickoff + 1); // words from one pair to the next
	localparam int cycle_words = 1 << (pickoff + 3);
	localparam int burst_words = 8;
	localparam int watchdog_cycles = 2500; // tests need roughly 1200 clocks

	logic clock = 1'b0;
	logic reset1;
	logic trigger_in;
	logic self_triggered;
	logic serial_out;
	logic frame_out;
	logic sync_out;
	logic [word_width-1:0] leds;

	logic [word_width-1:0] prev_leds; // leds one clock back
	logic prev_sync;
	logic [word_width-1:0] rx_word;
	logic [word_width-1:0] rx_expected;
	int rx_bits;
	int since_frame;
	int words_checked;
	logic [word_width-1:0] words_q[$]; // one entry per frame
	logic sync_q[$];
	logic [15:0] lfsr_state = 16'd46;

	trigger_serdes_top DUT (.*);

	always #10 clock = ~clock;

	task automatic compare_value(input string test, input int expected, input int actual);
		assert (expected == actual) else begin
			$display("CHECK FAILED %s: expected %0h, actual %0h", test, expected, actual);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic require(input logic cond, input string what);
		assert (cond) else begin
			$display("ERROR: %s", what);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
	endfunction

	task automatic random_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			value = (value << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	function automatic logic [word_width-1:0] pattern_word(input int index);
		case (index)
			0: return pattern_first_a;
			1: return pattern_first_b;
			2: return pattern_second_a;
			3: return pattern_second_b;
			4: return pattern_third_a;
			5: return pattern_third_b;
			6: return pattern_fourth_a;
			default: return pattern_fourth_b;
		endcase
	endfunction

	// a/b pair opens each spacing block and zeros fill the rest
	function automatic logic [word_width-1:0] expected_self_word(input int index);
		int position;
		int slot;
		position = index % cycle_words;
		slot = position % pair_spacing;
		if (slot < 2) begin
			return pattern_word(2 * (position / pair_spacing) + slot);
		end
		return '0;
	endfunction

	task automatic step_clocks(input int count);
		repeat (count) @(posedge clock);
		#drive_delay;
	endtask

	task automatic pulse_trigger(input int high_clocks);
		trigger_in = 1'b1;
		step_clocks(high_clocks);
		trigger_in = 1'b0;
	endtask

	task automatic clear_capture();
		words_q.delete();
		sync_q.delete();
	endtask

	task automatic wait_words(input int count);
		int limit;
		limit = (count + 2) * word_width * 2;
		while (words_q.size() < count && limit > 0) begin
			@(posedge clock);
			limit--;
		end
		require(words_q.size() >= count, "expected words did not arrive on serial_out");
		#drive_delay;
	endtask

	task automatic idle_outputs(input string test);
		compare_value({test, " serial_out"}, 0, int'(serial_out));
		compare_value({test, " frame_out"}, 0, int'(frame_out));
		compare_value({test, " sync_out"}, 0, int'(sync_out));
		compare_value({test, " leds"}, 0, int'(leds));
	endtask

	// exactly one burst with zeros around it and sync on its first word only
	task automatic burst_check(input string test);
		int first;
		int expected_word;
		first = -1;
		for (int i = 0; i < words_q.size(); i++) begin
			if (first < 0 && words_q[i] != '0) begin
				first = i;
			end
		end
		require(first > 0, {test, ": no burst, or no idle word ahead of it"});
		require(words_q.size() >= first + burst_words + 2, {test, ": too few words after burst"});
		for (int i = 0; i < words_q.size(); i++) begin
			expected_word = 0;
			if (i >= first && i < first + burst_words) begin
				expected_word = int'(pattern_word(i - first));
			end
			compare_value($sformatf("%s word %0d", test, i), expected_word, int'(words_q[i]));
			compare_value($sformatf("%s sync %0d", test, i), (i == first) ? 1 : 0,
				int'(sync_q[i]));
		end
	endtask

	// receiver rebuilds each word from serial_out starting at frame_out
	always @(negedge clock) begin
		if (reset1) begin
			rx_bits = 0;
			since_frame = -1;
		end else begin
			if (since_frame >= 0) begin
				since_frame++;
			end
			if (frame_out) begin
				if (since_frame >= 0) begin
					compare_value("serialization frame spacing", word_width, since_frame);
				end
				since_frame = 0;
				rx_expected = prev_leds;
				words_q.push_back(prev_leds);
				sync_q.push_back(prev_sync);
				rx_word = {{(word_width - 1){1'b0}}, serial_out};
				rx_bits = 1;
			end else if (rx_bits > 0) begin
				rx_word = {rx_word[word_width-2:0], serial_out}; // MSB came first
				rx_bits++;
			end
			if (rx_bits == word_width) begin
				compare_value("serialization", int'(rx_expected), int'(rx_word));
				words_checked++;
				rx_bits = 0;
			end
		end
		prev_leds = leds;
		prev_sync = sync_out;
	end

	task automatic reset_idle_test();
		int n;
		reset1 = 1'b1;
		clear_capture();
		step_clocks(reset_cycles);
		idle_outputs("reset_idle in reset");
		reset1 = 1'b0;
		n = 0;
		do begin
			@(posedge clock);
			n++;
			@(negedge clock);
			if (n <= ready_clocks) begin
				idle_outputs("reset_idle ready delay");
			end
		end while (!frame_out && n < ready_clocks + 4 * word_width);
		// ready plus the strobe clock and the serializer load
		compare_value("reset_idle first frame clock", ready_clocks + 2, n);
		step_clocks(1);
	endtask

	task automatic serialization_test();
		int start;
		int limit;
		start = words_checked;
		limit = 6 * word_width;
		while (words_checked < start + 4 && limit > 0) begin
			@(posedge clock);
			limit--;
		end
		require(words_checked >= start + 4, "receiver stopped getting words from serial_out");
		#drive_delay;
	endtask

	task automatic self_pattern_test();
		wait_words(2 * cycle_words);
		for (int i = 0; i < 2 * cycle_words; i++) begin
			compare_value($sformatf("self_pattern word %0d", i), int'(expected_self_word(i)),
				int'(words_q[i]));
		end
	endtask

	task automatic sync_marker_test();
		for (int i = 0; i < 2 * cycle_words; i++) begin
			// up with first_a and down with second_a
			compare_value($sformatf("sync_marker word %0d", i),
				((i % cycle_words) < pair_spacing) ? 1 : 0, int'(sync_q[i]));
		end
	endtask

	task automatic external_burst_test();
		int delay;
		self_triggered = 1'b0;
		step_clocks(3 * word_width); // last pattern word drains
		clear_capture();
		random_bits(4, delay);
		step_clocks(2 * word_width + delay);
		pulse_trigger(sync_stages + 2);
		wait_words(20);
		burst_check("external_burst");
	endtask

	task automatic retrigger_test();
		int gap;
		clear_capture();
		step_clocks(2 * word_width);
		pulse_trigger(sync_stages + 2);
		random_bits(4, gap);
		step_clocks(3 * word_width + gap); // well inside the burst
		pulse_trigger(sync_stages + 2);
		wait_words(24);
		burst_check("retrigger in burst");
		clear_capture();
		step_clocks(2 * word_width);
		pulse_trigger(sync_stages + 2);
		wait_words(20);
		burst_check("retrigger after burst");
	endtask

	initial begin
		reset1 = 1'b1;
		trigger_in = 1'b0;
		self_triggered = 1'b1;
		reset_idle_test();
		serialization_test();
		self_pattern_test();
		sync_marker_test();
		external_burst_test();
		retrigger_test();
		$display("Everything OK");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("timeout: tests still running after %0d clocks", watchdog_cycles);
		$display("Something failed");
		$fatal(1);
	end

endmodule

/* trigger_serdes.f */
verilog/trigger_pkg.sv
verilog/reset_sequencer.sv
verilog/trigger_edge_detect.sv
verilog/pattern_sequencer.sv
verilog/word_serializer.sv
verilog/trigger_serdes_top.sv
tb/trigger_serdes_tb.sv

/* verilog/pattern_sequencer.sv */
`timescale 1ns/1ps

module pattern_sequencer (
	input  logic clock,
	input  logic reset1,
	input  logic ready,
	input  logic word_strobe,
	input  logic trigger_pulse,
	input  logic self_triggered,
	output logic [trigger_pkg::word_width-1:0] word,
	output logic sync_marker
);
	import trigger_pkg::*;

	logic [pickoff+2:0] word_count; // one full self-triggered cycle
	logic [1:0] pair_select;
	logic pattern_slot; // counter sits on a pattern pair
	logic trigger_pending;
	burst_state_t state;

	assign pair_select = word_count[pickoff+2:pickoff+1];
	assign pattern_slot = (word_count[pickoff:1] == '0);

	always_ff @(posedge clock) begin
		if (reset1) begin
			word <= '0;
			sync_marker <= 1'b0;
			word_count <= '0;
			trigger_pending <= 1'b0;
			state <= burst_idle;
		end else begin
			// only take a trigger while nothing is queued or running
			if (ready && !self_triggered && trigger_pulse
					&& state == burst_idle && !trigger_pending) begin
				trigger_pending <= 1'b1;
			end

			if (ready && word_strobe) begin
				word_count <= word_count + 1'b1;
				if (self_triggered) begin
					state <= burst_idle; // abandon any burst
					trigger_pending <= 1'b0;
					word <= '0; // gap between pairs
					if (pattern_slot) begin
						case (pair_select)
							2'd0: begin
								sync_marker <= 1'b1;
								word <= word_count[0] ? pattern_first_b : pattern_first_a;
							end
							2'd1: begin
								sync_marker <= 1'b0;
								word <= word_count[0] ? pattern_second_b : pattern_second_a;
							end
							2'd2: word <= word_count[0] ? pattern_third_b : pattern_third_a;
							default: word <= word_count[0] ? pattern_fourth_b : pattern_fourth_a;
						endcase
					end
				end else begin
					sync_marker <= 1'b0; // high for first_a only
					case (state)
						burst_idle: begin
							word <= '0;
							if (trigger_pending) begin
								trigger_pending <= 1'b0;
								sync_marker <= 1'b1;
								word <= pattern_first_a;
								state <= burst_first_a;
							end
						end
						burst_first_a: begin
							word <= pattern_first_b;
							state <= burst_first_b;
						end
						burst_first_b: begin
							word <= pattern_second_a;
							state <= burst_second_a;
						end
						burst_second_a: begin
							word <= pattern_second_b;
							state <= burst_second_b;
						end
						burst_second_b: begin
							word <= pattern_third_a;
							state <= burst_third_a;
						end
						burst_third_a: begin
							word <= pattern_third_b;
							state <= burst_third_b;
						end
						burst_third_b: begin
							word <= pattern_fourth_a;
							state <= burst_fourth_a;
						end
						burst_fourth_a: begin
							word <= pattern_fourth_b;
							state <= burst_fourth_b;
						end
						default: begin
							word <= '0; // burst done
							state <= burst_idle;
						end
					endcase
				end
			end
		end
	end

	// a burst may only start on a word boundary
	burst_start_on_strobe: assert property (
		@(posedge clock) disable iff (reset1)
		(state == burst_idle && !word_strobe) |=> state == burst_idle
	) else $error("burst left idle without a word strobe");

endmodule

/* verilog/reset_sequencer.sv */
`timescale 1ns/1ps

module reset_sequencer (
	input  logic clock,
	input  logic reset1,
	output logic ready
);
	import trigger_pkg::*;

	// top bit doubles as the ready flag
	logic [ready_delay_bits:0] delay_count;

	always_ff @(posedge clock) begin
		if (reset1) begin
			delay_count <= '0;
		end else if (!delay_count[ready_delay_bits]) begin
			delay_count <= delay_count + 1'b1; // stops once top bit is set
		end
	end

	assign ready = delay_count[ready_delay_bits];

	// once up, ready only drops through reset1
	ready_holds: assert property (
		@(posedge clock) $fell(ready) |-> $past(reset1)
	) else $error("ready fell without reset1");

endmodule

/* verilog/trigger_edge_detect.sv */
`timescale 1ns/1ps

module trigger_edge_detect (
	input  logic clock,
	input  logic reset1,
	input  logic trigger_in,
	output logic trigger_pulse
);
	import trigger_pkg::*;

	logic [sync_stages-1:0] sync_chain; // metastability chain
	logic trigger_history; // previous synchronized sample

	always_ff @(posedge clock) begin
		if (reset1) begin
			sync_chain <= '0;
			trigger_history <= 1'b0;
			trigger_pulse <= 1'b0;
		end else begin
			sync_chain <= {sync_chain[sync_stages-2:0], trigger_in};
			trigger_history <= sync_chain[sync_stages-1];
			// rising pattern 0 -> 1 in the last two samples
			trigger_pulse <= sync_chain[sync_stages-1] & ~trigger_history;
		end
	end

	// a held-high trigger must not give a stretched pulse
	pulse_single: assert property (
		@(posedge clock) disable iff (reset1)
		trigger_pulse |=> !trigger_pulse
	) else $error("trigger_pulse high two clocks in a row");

endmodule

/* verilog/trigger_pkg.sv */
package trigger_pkg;

	localparam int word_width = 8; // bits per serialized word
	localparam int pickoff = 2; // self-triggered spacing, 2^(pickoff+1) words per pair
	localparam int ready_delay_bits = 6; // ready after 2^6 clocks
	localparam int sync_stages = 3; // flops on the async trigger

	// trigger pattern, emitted as a/b pairs
	localparam logic [word_width-1:0] pattern_first_a  = 8'hff;
	localparam logic [word_width-1:0] pattern_first_b  = 8'hff;
	localparam logic [word_width-1:0] pattern_second_a = 8'hf3;
	localparam logic [word_width-1:0] pattern_second_b = 8'h99;
	localparam logic [word_width-1:0] pattern_third_a  = 8'h80;
	localparam logic [word_width-1:0] pattern_third_b  = 8'h01;
	localparam logic [word_width-1:0] pattern_fourth_a = 8'hcc;
	localparam logic [word_width-1:0] pattern_fourth_b = 8'haa;

	// burst FSM, each state names the word currently on the output
	typedef enum logic [3:0] {
		burst_idle,
		burst_first_a,
		burst_first_b,
		burst_second_a,
		burst_second_b,
		burst_third_a,
		burst_third_b,
		burst_fourth_a,
		burst_fourth_b
	} burst_state_t;

endpackage

/* verilog/trigger_serdes_top.sv */
`timescale 1ns/1ps

module trigger_serdes_top (
	input  logic clock,
	input  logic reset1,
	input  logic trigger_in, // async
	input  logic self_triggered,
	output logic serial_out,
	output logic frame_out,
	output logic sync_out,
	output logic [trigger_pkg::word_width-1:0] leds
);
	import trigger_pkg::*;

	logic ready;
	logic trigger_pulse;
	logic word_strobe;
	logic [word_width-1:0] word;
	logic sync_marker;

	reset_sequencer u_reset_sequencer (
		.clock (clock),
		.reset1(reset1),
		.ready (ready)
	);

	trigger_edge_detect u_trigger_edge_detect (
		.clock        (clock),
		.reset1       (reset1),
		.trigger_in   (trigger_in),
		.trigger_pulse(trigger_pulse)
	);

	pattern_sequencer u_pattern_sequencer (
		.clock         (clock),
		.reset1        (reset1),
		.ready         (ready),
		.word_strobe   (word_strobe),
		.trigger_pulse (trigger_pulse),
		.self_triggered(self_triggered),
		.word          (word),
		.sync_marker   (sync_marker)
	);

	word_serializer u_word_serializer (
		.clock      (clock),
		.reset1     (reset1),
		.ready      (ready),
		.word       (word),
		.word_strobe(word_strobe),
		.serial_out (serial_out),
		.frame_out  (frame_out)
	);

	assign sync_out = sync_marker;
	assign leds = word; // current word on the LED byte

endmodule

/* verilog/word_serializer.sv */
`timescale 1ns/1ps

module word_serializer (
	input  logic clock,
	input  logic reset1,
	input  logic ready,
	input  logic [trigger_pkg::word_width-1:0] word,
	output logic word_strobe,
	output logic serial_out,
	output logic frame_out
);
	import trigger_pkg::*;

	logic [2:0] bit_count; // position within the 8-bit word
	logic load; // take the word updated on the last strobe
	logic [word_width-1:0] shift_reg;

	// strobe at slot 0, the sequencer updates word on that edge
	assign word_strobe = ready && (bit_count == 3'd0);
	assign load = ready && (bit_count == 3'd1);

	always_ff @(posedge clock) begin
		if (reset1) begin
			bit_count <= '0;
		end else if (ready) begin
			bit_count <= bit_count + 1'b1; // wraps every 8 clocks
		end
	end

	always_ff @(posedge clock) begin
		if (reset1) begin
			shift_reg <= '0;
			frame_out <= 1'b0;
		end else begin
			frame_out <= load; // marks the MSB cycle
			if (load) begin
				shift_reg <= word;
			end else begin
				shift_reg <= {shift_reg[word_width-2:0], 1'b0}; // MSB first
			end
		end
	end

	assign serial_out = shift_reg[word_width-1];

	// frames recur with an exact 8-cycle spacing
	frame_period: assert property (
		@(posedge clock) disable iff (reset1 || !ready)
		frame_out |=> !frame_out [*7] ##1 frame_out
	) else $error("frame_out period is not 8 cycles");

endmodule
